// ==== Makefile ====
TOP = lpipe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f flist.f

# Pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== flist.f ====
hdl/lpipe_pkg.sv
hdl/lpipe_if.sv
hdl/oitf.sv
hdl/disp_stage.sv
hdl/regfile.sv
hdl/long_mac.sv
hdl/wback_stage.sv
hdl/lpipe_top.sv
test/lpipe_chk.sv
test/lpipe_tb.sv

// ==== hdl/disp_stage.sv ====
`timescale 1ns/10ps

module disp_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              in_rs1en,
  input  logic              in_rs2en,
  input  logic              in_rs1fpu,
  input  logic              in_rs2fpu,
  input  logic              in_rdwen,
  input  logic              in_rdfpu,
  input  lpipe_pkg::rfidx_t in_rs1idx,
  input  lpipe_pkg::rfidx_t in_rs2idx,
  input  lpipe_pkg::rfidx_t in_rdidx,
  input  lpipe_pkg::xlen_t  in_imm,
  input  lpipe_pkg::pc_t    in_pc,
  input  lpipe_pkg::xlen_t  rs1_data,
  input  lpipe_pkg::xlen_t  rs2_data,
  oitf_disp_if.disp         oitf,
  lp_issue_if.src           issue
);

  logic accept;

  // Request fields go straight to the FIFO for matching
  assign oitf.rs1en  = in_rs1en;
  assign oitf.rs2en  = in_rs2en;
  assign oitf.rs1fpu = in_rs1fpu;
  assign oitf.rs2fpu = in_rs2fpu;
  assign oitf.rs1idx = in_rs1idx;
  assign oitf.rs2idx = in_rs2idx;
  assign oitf.rdwen  = in_rdwen;
  assign oitf.rdfpu  = in_rdfpu;
  assign oitf.rdidx  = in_rdidx;
  assign oitf.pc     = in_pc;

  // RAW and WAW both stall
  assign in_ready  = oitf.ready & ~(oitf.match_rs1 | oitf.match_rs2 | oitf.match_rd);
  assign accept    = in_valid & in_ready;
  assign oitf.ena  = accept;

  // ########################################
  // Issue register
  // ########################################

  always_ff @(posedge clk) begin
    if (reset)
      issue.valid <= 1'b0;
    else
      issue.valid <= accept;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue.itag <= oitf.dis_ptr;
      issue.op_a <= in_rs1en ? rs1_data : '0;   // Disabled source is zero
      issue.op_b <= in_rs2en ? rs2_data : '0;
      issue.imm  <= in_imm;
    end
  end

endmodule

// ==== hdl/long_mac.sv ====
`timescale 1ns/10ps

module long_mac (
  input logic     clk,
  input logic     reset,
  lp_issue_if.dst in,
  lp_issue_if.src out
);

  logic [lpipe_pkg::MAC_LAT-1:0] vld_q;
  lpipe_pkg::itag_t              tag_q [lpipe_pkg::MAC_LAT];

  lpipe_pkg::xlen_t prod_q;
  lpipe_pkg::xlen_t imm_q;
  lpipe_pkg::xlen_t sum_q;
  lpipe_pkg::xlen_t res_q;

  // Valid travels down a shift register, never stalls
  always_ff @(posedge clk) begin
    if (reset)
      vld_q <= '0;
    else
      vld_q <= {vld_q[lpipe_pkg::MAC_LAT-2:0], in.valid};
  end

  always_ff @(posedge clk) begin
    tag_q[0] <= in.itag;
    for (int i = 1; i < lpipe_pkg::MAC_LAT; i++)
      tag_q[i] <= tag_q[i-1];
  end

  // ########################################
  // Datapath
  // ########################################

  always_ff @(posedge clk) begin
    if (in.valid) begin
      prod_q <= in.op_a * in.op_b;   // Low 32 bits only
      imm_q  <= in.imm;
    end
    if (vld_q[0])
      sum_q <= prod_q + imm_q;
    if (vld_q[1])
      res_q <= sum_q;
  end

  assign out.valid = vld_q[lpipe_pkg::MAC_LAT-1];
  assign out.itag  = tag_q[lpipe_pkg::MAC_LAT-1];
  assign out.op_a  = res_q;

  // Result side carries only op_a
  assign out.op_b  = '0;
  assign out.imm   = '0;

endmodule

// ==== hdl/lpipe_if.sv ====
`timescale 1ns/10ps

// Dispatch request towards the track FIFO, and its answer
interface oitf_disp_if;
  logic                ena;
  logic                ready;
  lpipe_pkg::itag_t    dis_ptr;
  logic                rs1en;
  logic                rs2en;
  logic                rs1fpu;
  logic                rs2fpu;
  lpipe_pkg::rfidx_t   rs1idx;
  lpipe_pkg::rfidx_t   rs2idx;
  logic                rdwen;
  logic                rdfpu;
  lpipe_pkg::rfidx_t   rdidx;
  lpipe_pkg::pc_t      pc;
  logic                match_rs1;
  logic                match_rs2;
  logic                match_rd;

  modport disp (output ena, rs1en, rs2en, rs1fpu, rs2fpu, rs1idx, rs2idx,
                output rdwen, rdfpu, rdidx, pc,
                input  ready, dis_ptr, match_rs1, match_rs2, match_rd);
  modport oitf (input  ena, rs1en, rs2en, rs1fpu, rs2fpu, rs1idx, rs2idx,
                input  rdwen, rdfpu, rdidx, pc,
                output ready, dis_ptr, match_rs1, match_rs2, match_rd);
endinterface

// Strobe-only transfer inside the long pipe
interface lp_issue_if;
  logic               valid;
  lpipe_pkg::itag_t   itag;
  lpipe_pkg::xlen_t   op_a;
  lpipe_pkg::xlen_t   op_b;
  lpipe_pkg::xlen_t   imm;

  modport src (output valid, itag, op_a, op_b, imm);
  modport dst (input  valid, itag, op_a, op_b, imm);
endinterface

// Retirement of the FIFO head
interface oitf_ret_if;
  logic                ena;
  lpipe_pkg::itag_t    ptr;
  lpipe_pkg::rfidx_t   rdidx;
  logic                rdwen;
  logic                rdfpu;
  lpipe_pkg::pc_t      pc;
  logic                empty;   // Nothing in flight

  modport wb   (output ena, input ptr, rdidx, rdwen, rdfpu, pc);
  modport oitf (input ena, output ptr, rdidx, rdwen, rdfpu, pc, empty);
endinterface

// ==== hdl/lpipe_pkg.sv ====
package lpipe_pkg;

  // ########################################
  // Sizes
  // ########################################

  localparam int OITF_DEPTH  = 4;   // Outstanding instructions
  localparam int ITAG_WIDTH  = 2;   // Entry pointer into the track FIFO
  localparam int MAC_LAT     = 3;   // Register stages in the multiply-add pipe

  localparam int RFIDX_WIDTH = 5;
  localparam int XLEN        = 32;
  localparam int PC_SIZE     = 32;

  // ########################################
  // Shared vector types
  // ########################################

  // Register index, the bank is selected by a separate fpu bit
  typedef logic [RFIDX_WIDTH-1:0] rfidx_t;

  // Instruction tag, equal to the FIFO entry it occupies
  typedef logic [ITAG_WIDTH-1:0] itag_t;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [PC_SIZE-1:0] pc_t;

endpackage

// ==== hdl/lpipe_top.sv ====
`timescale 1ns/10ps

module lpipe_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              in_rs1en,
  input  logic              in_rs2en,
  input  logic              in_rs1fpu,
  input  logic              in_rs2fpu,
  input  logic              in_rdwen,
  input  logic              in_rdfpu,
  input  lpipe_pkg::rfidx_t in_rs1idx,
  input  lpipe_pkg::rfidx_t in_rs2idx,
  input  lpipe_pkg::rfidx_t in_rdidx,
  input  lpipe_pkg::xlen_t  in_imm,
  input  lpipe_pkg::pc_t    in_pc,
  output logic              wb_valid,
  output logic              wb_rdwen,
  output logic              wb_rdfpu,
  output lpipe_pkg::rfidx_t wb_rdidx,
  output lpipe_pkg::xlen_t  wb_data,
  output lpipe_pkg::pc_t    wb_pc,
  output logic              idle
);

  oitf_disp_if disp_bus ();
  oitf_ret_if  ret_bus ();
  lp_issue_if  lp_issue ();
  lp_issue_if  lp_res ();

  lpipe_pkg::xlen_t  rs1_data;
  lpipe_pkg::xlen_t  rs2_data;
  logic              rf_we;
  logic              rf_wfpu;
  lpipe_pkg::rfidx_t rf_widx;
  lpipe_pkg::xlen_t  rf_wdata;

  disp_stage disp_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_rs1en  (in_rs1en),
    .in_rs2en  (in_rs2en),
    .in_rs1fpu (in_rs1fpu),
    .in_rs2fpu (in_rs2fpu),
    .in_rdwen  (in_rdwen),
    .in_rdfpu  (in_rdfpu),
    .in_rs1idx (in_rs1idx),
    .in_rs2idx (in_rs2idx),
    .in_rdidx  (in_rdidx),
    .in_imm    (in_imm),
    .in_pc     (in_pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .oitf      (disp_bus.disp),
    .issue     (lp_issue.src)
  );

  oitf oitf_inst (
    .clk   (clk),
    .reset (reset),
    .disp  (disp_bus.oitf),
    .ret   (ret_bus.oitf)
  );

  // Operands are read in the dispatch cycle
  regfile regfile_inst (
    .clk      (clk),
    .reset    (reset),
    .rs1fpu   (in_rs1fpu),
    .rs2fpu   (in_rs2fpu),
    .rs1idx   (in_rs1idx),
    .rs2idx   (in_rs2idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .wfpu     (rf_wfpu),
    .widx     (rf_widx),
    .wdata    (rf_wdata)
  );

  long_mac long_mac_inst (
    .clk   (clk),
    .reset (reset),
    .in    (lp_issue.dst),
    .out   (lp_res.src)
  );

  wback_stage wback_stage_inst (
    .res      (lp_res.dst),
    .ret      (ret_bus.wb),
    .we       (rf_we),
    .wfpu     (rf_wfpu),
    .widx     (rf_widx),
    .wdata    (rf_wdata),
    .wb_valid (wb_valid),
    .wb_rdwen (wb_rdwen),
    .wb_rdfpu (wb_rdfpu),
    .wb_rdidx (wb_rdidx),
    .wb_data  (wb_data),
    .wb_pc    (wb_pc)
  );

  assign idle = ret_bus.empty;

endmodule

// ==== hdl/oitf.sv ====
`timescale 1ns/10ps

module oitf (
  input logic       clk,
  input logic       reset,
  oitf_disp_if.oitf disp,
  oitf_ret_if.oitf  ret
);

  // Pointer with its wrap flag on top
  logic [lpipe_pkg::ITAG_WIDTH:0] alc_q;
  logic [lpipe_pkg::ITAG_WIDTH:0] ret_q;

  lpipe_pkg::itag_t alc_ptr;
  lpipe_pkg::itag_t ret_ptr;
  logic             empty;
  logic             full;

  logic [lpipe_pkg::OITF_DEPTH-1:0] vld_q;
  logic [lpipe_pkg::OITF_DEPTH-1:0] rdwen_q;
  logic [lpipe_pkg::OITF_DEPTH-1:0] rdfpu_q;
  lpipe_pkg::rfidx_t                rdidx_q [lpipe_pkg::OITF_DEPTH];
  lpipe_pkg::pc_t                   pc_q    [lpipe_pkg::OITF_DEPTH];

  logic [lpipe_pkg::OITF_DEPTH-1:0] live;
  logic [lpipe_pkg::OITF_DEPTH-1:0] m_rs1;
  logic [lpipe_pkg::OITF_DEPTH-1:0] m_rs2;
  logic [lpipe_pkg::OITF_DEPTH-1:0] m_rd;

  function automatic logic [lpipe_pkg::ITAG_WIDTH:0] ptr_inc(
    input logic [lpipe_pkg::ITAG_WIDTH:0] p
  );
    logic [lpipe_pkg::ITAG_WIDTH:0] n;
    if (p[lpipe_pkg::ITAG_WIDTH-1:0] == lpipe_pkg::itag_t'(lpipe_pkg::OITF_DEPTH - 1))
      n = {~p[lpipe_pkg::ITAG_WIDTH], {lpipe_pkg::ITAG_WIDTH{1'b0}}};
    else
      n = p + 1'b1;
    return n;
  endfunction

  // ########################################
  // Pointers
  // ########################################

  always_ff @(posedge clk) begin
    if (reset) begin
      alc_q <= '0;
      ret_q <= '0;
    end else begin
      if (disp.ena) alc_q <= ptr_inc(alc_q);
      if (ret.ena)  ret_q <= ptr_inc(ret_q);
    end
  end

  assign alc_ptr = alc_q[lpipe_pkg::ITAG_WIDTH-1:0];
  assign ret_ptr = ret_q[lpipe_pkg::ITAG_WIDTH-1:0];
  assign empty   = (alc_q == ret_q);
  assign full    = (alc_ptr == ret_ptr) &
                   (alc_q[lpipe_pkg::ITAG_WIDTH] != ret_q[lpipe_pkg::ITAG_WIDTH]);

  // Retirement is kept out of ready to avoid a loop back into dispatch
  assign disp.ready   = ~full;
  assign disp.dis_ptr = alc_ptr;

  // ########################################
  // Entries
  // ########################################

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      for (int i = 0; i < lpipe_pkg::OITF_DEPTH; i++) begin
        if (disp.ena && alc_ptr == lpipe_pkg::itag_t'(i))
          vld_q[i] <= 1'b1;
        else if (ret.ena && ret_ptr == lpipe_pkg::itag_t'(i))
          vld_q[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < lpipe_pkg::OITF_DEPTH; i++) begin
      if (disp.ena && alc_ptr == lpipe_pkg::itag_t'(i)) begin
        rdwen_q[i] <= disp.rdwen;
        rdfpu_q[i] <= disp.rdfpu;
        rdidx_q[i] <= disp.rdidx;
        pc_q[i]    <= disp.pc;
      end
    end
  end

  // Hazard match against every live destination
  assign live = vld_q & rdwen_q;

  always_comb begin
    for (int i = 0; i < lpipe_pkg::OITF_DEPTH; i++) begin
      m_rs1[i] = live[i] & disp.rs1en & (rdfpu_q[i] == disp.rs1fpu) & (rdidx_q[i] == disp.rs1idx);
      m_rs2[i] = live[i] & disp.rs2en & (rdfpu_q[i] == disp.rs2fpu) & (rdidx_q[i] == disp.rs2idx);
      m_rd[i]  = live[i] & disp.rdwen & (rdfpu_q[i] == disp.rdfpu) & (rdidx_q[i] == disp.rdidx);
    end
  end

  assign disp.match_rs1 = |m_rs1;
  assign disp.match_rs2 = |m_rs2;
  assign disp.match_rd  = |m_rd;

  // Head read-out
  assign ret.ptr   = ret_ptr;
  assign ret.rdidx = rdidx_q[ret_ptr];
  assign ret.rdwen = rdwen_q[ret_ptr];
  assign ret.rdfpu = rdfpu_q[ret_ptr];
  assign ret.pc    = pc_q[ret_ptr];
  assign ret.empty = empty;

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps

module regfile (
  input  logic              clk,
  input  logic              reset,
  input  logic              rs1fpu,
  input  logic              rs2fpu,
  input  lpipe_pkg::rfidx_t rs1idx,
  input  lpipe_pkg::rfidx_t rs2idx,
  output lpipe_pkg::xlen_t  rs1_data,
  output lpipe_pkg::xlen_t  rs2_data,
  input  logic              we,
  input  logic              wfpu,
  input  lpipe_pkg::rfidx_t widx,
  input  lpipe_pkg::xlen_t  wdata
);

  lpipe_pkg::xlen_t xreg_q [2**lpipe_pkg::RFIDX_WIDTH];   // Integer bank
  lpipe_pkg::xlen_t freg_q [2**lpipe_pkg::RFIDX_WIDTH];   // Floating-point bank

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**lpipe_pkg::RFIDX_WIDTH; i++) begin
        xreg_q[i] <= '0;
        freg_q[i] <= '0;
      end
    end else if (we) begin
      if (wfpu)
        freg_q[widx] <= wdata;
      else if (widx != '0)
        xreg_q[widx] <= wdata;   // x0 stays zero
    end
  end

  assign rs1_data = rs1fpu ? freg_q[rs1idx] : xreg_q[rs1idx];
  assign rs2_data = rs2fpu ? freg_q[rs2idx] : xreg_q[rs2idx];

endmodule

// ==== hdl/wback_stage.sv ====
`timescale 1ns/10ps

module wback_stage (
  lp_issue_if.dst           res,
  oitf_ret_if.wb            ret,
  output logic              we,
  output logic              wfpu,
  output lpipe_pkg::rfidx_t widx,
  output lpipe_pkg::xlen_t  wdata,
  output logic              wb_valid,
  output logic              wb_rdwen,
  output logic              wb_rdfpu,
  output lpipe_pkg::rfidx_t wb_rdidx,
  output lpipe_pkg::xlen_t  wb_data,
  output lpipe_pkg::pc_t    wb_pc
);

  // Results come back in dispatch order, so the head is always the owner
  assign ret.ena = res.valid;

  // Register file write
  assign we    = res.valid & ret.rdwen;
  assign wfpu  = ret.rdfpu;
  assign widx  = ret.rdidx;
  assign wdata = res.op_a;

  // Retirement report
  assign wb_valid = res.valid;
  assign wb_rdwen = ret.rdwen;
  assign wb_rdfpu = ret.rdfpu;
  assign wb_rdidx = ret.rdidx;
  assign wb_data  = res.op_a;
  assign wb_pc    = ret.pc;

endmodule

// ==== test/lpipe_chk.sv ====
`timescale 1ns/10ps

module lpipe_chk (
  input logic             clk,
  input logic             reset,
  input logic             alloc,
  input logic             retire,
  input logic             full,
  input logic             empty,
  input lpipe_pkg::itag_t alc_ptr,
  input lpipe_pkg::itag_t ret_ptr
);

  localparam int LAT = lpipe_pkg::MAC_LAT + 1;   // Dispatch register plus the MAC stages

  a_alloc_not_full: assert property (@(posedge clk) disable iff (reset) alloc |-> !full)
    else $error("track FIFO allocated an entry while full");

  a_retire_not_empty: assert property (@(posedge clk) disable iff (reset) retire |-> !empty)
    else $error("track FIFO retired an entry while empty");

  // The itag rides the pipe, so each result must free the entry allocated LAT edges before
  a_retire_tag: assert property (@(posedge clk) disable iff (reset)
    retire |-> $past(alloc, LAT) && (ret_ptr == $past(alc_ptr, LAT)))
    else $error("pipe result does not belong to the FIFO head entry");

endmodule

bind oitf lpipe_chk lpipe_chk_inst (
  .clk     (clk),
  .reset   (reset),
  .alloc   (disp.ena),
  .retire  (ret.ena),
  .full    (full),
  .empty   (empty),
  .alc_ptr (alc_ptr),
  .ret_ptr (ret_ptr)
);

// ==== test/lpipe_tb.sv ====
`timescale 1ns/10ps

module lpipe_tb;

  localparam int PERIOD    = 40;
  localparam int RESET_CYC = 10;
  localparam int RUN_CYC   = 2000;
  localparam int MARGIN    = 100;
  localparam int LATENCY   = 4;    // Accepting cycle to retiring cycle
  localparam int BURST_LEN = 40;   // Hazard-free cycles at the start of every 250

  typedef struct packed {
    int                due;
    logic              rdwen;
    logic              rdfpu;
    lpipe_pkg::rfidx_t rdidx;
    lpipe_pkg::pc_t    pc;
    lpipe_pkg::xlen_t  data;
  } retire_t;

  logic              clk;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  logic              in_rs1en;
  logic              in_rs2en;
  logic              in_rs1fpu;
  logic              in_rs2fpu;
  logic              in_rdwen;
  logic              in_rdfpu;
  lpipe_pkg::rfidx_t in_rs1idx;
  lpipe_pkg::rfidx_t in_rs2idx;
  lpipe_pkg::rfidx_t in_rdidx;
  lpipe_pkg::xlen_t  in_imm;
  lpipe_pkg::pc_t    in_pc;
  logic              wb_valid;
  logic              wb_rdwen;
  logic              wb_rdfpu;
  lpipe_pkg::rfidx_t wb_rdidx;
  lpipe_pkg::xlen_t  wb_data;
  lpipe_pkg::pc_t    wb_pc;
  logic              idle;

  logic [31:0]      lfsr;
  lpipe_pkg::xlen_t xreg [32];   // Model banks, written at acceptance
  lpipe_pkg::xlen_t freg [32];
  retire_t          exp_q [$];
  logic             in_burst;
  int               burst_idx;
  int               cyc;
  int               n_chk;
  int               n_err;
  int               n_acc;
  int               n_full;

  lpipe_top lpipe_top_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_rs1en  (in_rs1en),
    .in_rs2en  (in_rs2en),
    .in_rs1fpu (in_rs1fpu),
    .in_rs2fpu (in_rs2fpu),
    .in_rdwen  (in_rdwen),
    .in_rdfpu  (in_rdfpu),
    .in_rs1idx (in_rs1idx),
    .in_rs2idx (in_rs2idx),
    .in_rdidx  (in_rdidx),
    .in_imm    (in_imm),
    .in_pc     (in_pc),
    .wb_valid  (wb_valid),
    .wb_rdwen  (wb_rdwen),
    .wb_rdfpu  (wb_rdfpu),
    .wb_rdidx  (wb_rdidx),
    .wb_data   (wb_data),
    .wb_pc     (wb_pc),
    .idle      (idle)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYC + RUN_CYC + MARGIN) * PERIOD);
    $display("Timeout: the pipe did not drain within %0d cycles", RUN_CYC + MARGIN);
    $display("Finished with errors");
    $finish;
  end

  // ########################################
  // Helpers
  // ########################################

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic lpipe_pkg::xlen_t read_model(input logic fpu, input lpipe_pkg::rfidx_t idx);
    lpipe_pkg::xlen_t v;
    if (fpu)
      v = freg[idx];
    else
      v = (idx == '0) ? '0 : xreg[idx];   // x0 always reads zero
    return v;
  endfunction

  function automatic logic hits(input logic fpu, input lpipe_pkg::rfidx_t idx);
    logic h;
    h = 1'b0;
    foreach (exp_q[i])
      if (exp_q[i].rdwen && exp_q[i].rdfpu == fpu && exp_q[i].rdidx == idx)
        h = 1'b1;
    return h;
  endfunction

  // Pending list still holds the entry retiring in this cycle
  function automatic logic predict_ready();
    logic hazard;
    hazard = (in_rs1en && hits(in_rs1fpu, in_rs1idx)) ||
             (in_rs2en && hits(in_rs2fpu, in_rs2idx)) ||
             (in_rdwen && hits(in_rdfpu, in_rdidx));
    return !hazard && (exp_q.size() < lpipe_pkg::OITF_DEPTH);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_chk++;
    assert (act === exp) else begin
      n_err++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_chk++;
    assert (act === exp) else begin
      n_err++;
      $display("ERROR %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic drive_inputs();
    in_valid  = (take_bits(2) != 0);   // About 3 in 4
    in_rs1en  = (take_bits(2) != 0);
    in_rs2en  = (take_bits(2) != 0);
    in_rs1fpu = (take_bits(1) != 0);
    in_rs2fpu = (take_bits(1) != 0);
    in_rdwen  = (take_bits(2) != 0);
    in_rdfpu  = (take_bits(1) != 0);
    in_rs1idx = lpipe_pkg::rfidx_t'(take_bits(3));
    in_rs2idx = lpipe_pkg::rfidx_t'(take_bits(3));
    in_rdidx  = lpipe_pkg::rfidx_t'(take_bits(3));
    in_imm    = take_bits(32);
    in_pc     = take_bits(32);
    if (in_burst) begin
      // No sources and a rotating destination, so only a full FIFO stalls
      in_valid = 1'b1;
      in_rs1en = 1'b0;
      in_rs2en = 1'b0;
      in_rdwen = 1'b1;
      in_rdidx = lpipe_pkg::rfidx_t'(burst_idx % 8);
      in_rdfpu = burst_idx[3];
    end
  endtask

  // ########################################
  // Per-cycle check against the model
  // ########################################

  task automatic check_cycle();
    retire_t          head;
    retire_t          ent;
    lpipe_pkg::xlen_t a;
    lpipe_pkg::xlen_t b;
    check_bit("in_ready", predict_ready(), in_ready);
    check_bit("idle", exp_q.size() == 0, idle);
    if (in_valid && exp_q.size() == lpipe_pkg::OITF_DEPTH)
      n_full++;

    if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
      head = exp_q.pop_front();
      check_bit("wb_valid", 1'b1, wb_valid);
      check_bit("wb_rdwen", head.rdwen, wb_rdwen);
      check_bit("wb_rdfpu", head.rdfpu, wb_rdfpu);
      check_val("wb_rdidx", 32'(head.rdidx), 32'(wb_rdidx));
      check_val("wb_pc", head.pc, wb_pc);
      check_val("wb_data", head.data, wb_data);
    end else begin
      check_bit("wb_valid", 1'b0, wb_valid);
    end

    if (in_valid && in_ready) begin
      a = in_rs1en ? read_model(in_rs1fpu, in_rs1idx) : '0;
      b = in_rs2en ? read_model(in_rs2fpu, in_rs2idx) : '0;
      ent.due   = cyc + LATENCY;
      ent.rdwen = in_rdwen;
      ent.rdfpu = in_rdfpu;
      ent.rdidx = in_rdidx;
      ent.pc    = in_pc;
      ent.data  = a * b + in_imm;
      exp_q.push_back(ent);
      if (in_rdwen && in_rdfpu)
        freg[in_rdidx] = ent.data;
      else if (in_rdwen && in_rdidx != '0)
        xreg[in_rdidx] = ent.data;
      n_acc++;
      if (in_burst)
        burst_idx++;
    end
  endtask

  // ########################################
  // Main sequence
  // ########################################

  initial begin
    lfsr      = 32'h5ae0_2dc6;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_rs1en  = 1'b0;
    in_rs2en  = 1'b0;
    in_rs1fpu = 1'b0;
    in_rs2fpu = 1'b0;
    in_rdwen  = 1'b0;
    in_rdfpu  = 1'b0;
    in_rs1idx = '0;
    in_rs2idx = '0;
    in_rdidx  = '0;
    in_imm    = '0;
    in_pc     = '0;
    in_burst  = 1'b0;
    burst_idx = 0;
    cyc       = 0;
    n_chk     = 0;
    n_err     = 0;
    n_acc     = 0;
    n_full    = 0;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = '0;
      freg[i] = '0;
    end

    repeat (RESET_CYC) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    check_bit("reset in_ready", 1'b1, in_ready);
    check_bit("reset idle", 1'b1, idle);
    check_bit("reset wb_valid", 1'b0, wb_valid);

    while (cyc < RUN_CYC || exp_q.size() != 0) begin
      @(posedge clk);
      #2;
      cyc++;
      in_burst = (cyc % 250) < BURST_LEN;
      if (cyc <= RUN_CYC)
        drive_inputs();
      else
        in_valid = 1'b0;   // Drain
      @(negedge clk);
      check_cycle();
    end

    @(posedge clk);
    @(negedge clk);
    check_bit("drained idle", 1'b1, idle);
    check_bit("drained wb_valid", 1'b0, wb_valid);

    assert (n_full > 0) else begin
      n_err++;
      $display("The track FIFO never filled up during the hazard-free bursts");
    end

    $display("Accepted %0d, checks %0d, errors %0d", n_acc, n_chk, n_err);
    if (n_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
